// File: Makefile
# Verilator simulation of the reconfiguration path
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail unless it passes"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_drReconfigTop -f src.f
	./obj_dir/Vtb_drReconfigTop +verilator+error+limit+100 | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/drCtrlPkg.sv
`default_nettype none

package drCtrlPkg;

	// ====================
	// engine side

	// status code as driven by the reconfiguration engine
	typedef logic [2:0] engineStatusT;

	// ====================
	// control side

	// status word returned to the control side
	// fifo fill flag sits above the engine code
	typedef struct packed
	{
		logic         halfFull;
		engineStatusT engine;
	} drStatusT;

endpackage

`default_nettype wire

// File: hw/drReadPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "dr_cfg.svh"

module drReadPort
(
	input  wire                     DRCLK,
	input  wire                     DRFifoReset,
	input  wire drWordPkg::fifoLevelT rdLevel,
	input  wire drWordPkg::cfgWordT rdData,
	input  wire                     drReady,
	input  wire                     cfgRequest,
	output logic                    rdEn,
	output logic                    drValid,
	output drWordPkg::cfgWordT      drData,
	output logic                    drStart
);

	// request crossing from CLK50
	logic [`DR_SYNC_STAGES-1:0] reqSync;

	// ====================
	// word delivery

	assign drValid = |rdLevel;
	// pop only when the engine takes a valid word
	assign rdEn = drReady & drValid;
	assign drData = rdData;

	// ====================
	// start request

	always_ff @(posedge DRCLK or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			reqSync <= '0;
			drStart <= 1'b0;
		end
		else
		begin
			reqSync <= {reqSync[`DR_SYNC_STAGES-2:0], cfgRequest};
			drStart <= reqSync[`DR_SYNC_STAGES-1];
		end
	end

endmodule

`default_nettype wire

// File: hw/drReconfigTop.sv
`timescale 1ns/1ps
`default_nettype none

module drReconfigTop
(
	input  wire                          CLK50,
	input  wire                          DRCLK,
	input  wire                          DRFifoReset,
	input  wire drWordPkg::cfgWriteT     cfgWrite,
	input  wire                          cfgRequest,
	input  wire                          drFreeze,
	input  wire drCtrlPkg::engineStatusT drStatus,
	input  wire                          drReady,
	output wire                          drValid,
	output wire drWordPkg::cfgWordT      drData,
	output wire                          drStart,
	output wire                          cfgFreeze,
	output wire drCtrlPkg::drStatusT     cfgStatus
);

	// CLK50 side of the fifo
	wire wrEn;
	wire full;
	wire drWordPkg::cfgWordT wrData;
	wire drWordPkg::fifoLevelT wrLevel;

	// DRCLK side of the fifo
	wire rdEn;
	wire drWordPkg::cfgWordT rdData;
	wire drWordPkg::fifoLevelT rdLevel;

	drSequencer i_drSequencer (
		.CLK50(CLK50), .DRFifoReset(DRFifoReset), .cfgWrite(cfgWrite),
		.drFreeze(drFreeze), .drStatus(drStatus), .full(full), .wrLevel(wrLevel),
		.wrEn(wrEn), .wrData(wrData), .cfgFreeze(cfgFreeze), .cfgStatus(cfgStatus)
	);

	drWordFifo i_drWordFifo (
		.CLK50(CLK50), .DRCLK(DRCLK), .DRFifoReset(DRFifoReset),
		.wrEn(wrEn), .wrData(wrData), .full(full), .wrLevel(wrLevel),
		.rdEn(rdEn), .rdData(rdData), .rdLevel(rdLevel)
	);

	drReadPort i_drReadPort (
		.DRCLK(DRCLK), .DRFifoReset(DRFifoReset), .rdLevel(rdLevel), .rdData(rdData),
		.drReady(drReady), .cfgRequest(cfgRequest), .rdEn(rdEn), .drValid(drValid),
		.drData(drData), .drStart(drStart)
	);

endmodule

`default_nettype wire

// File: hw/drSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dr_cfg.svh"

module drSequencer
(
	input  wire                       CLK50,
	input  wire                       DRFifoReset,
	input  wire drWordPkg::cfgWriteT  cfgWrite,
	input  wire                       drFreeze,
	input  wire drCtrlPkg::engineStatusT drStatus,
	input  wire                       full,
	input  wire drWordPkg::fifoLevelT wrLevel,
	output logic                      wrEn,
	output drWordPkg::cfgWordT        wrData,
	output logic                      cfgFreeze,
	output drCtrlPkg::drStatusT       cfgStatus
);

	// drFreeze history, also brings it into CLK50
	logic [2:0] finishReg;
	logic freezeEnd;
	logic [`DR_INIT_BITS-1:0] initCnt;

	// ====================
	// fifo write port

	// words arriving while the fifo is full are lost
	assign wrEn = cfgWrite.strobe & ~full;
	assign wrData = cfgWrite.word;

	// ====================
	// end of freeze

	// falling edge of drFreeze after three flops
	assign freezeEnd = finishReg[2] & ~finishReg[1];

	always_ff @(posedge CLK50 or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
			finishReg <= '0;
		else
			finishReg <= {finishReg[1:0], drFreeze};
	end

	// reinit counter, started by the edge and free running until it wraps
	always_ff @(posedge CLK50 or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
			initCnt <= '0;
		else if ((|initCnt) | freezeEnd)
			initCnt <= initCnt + 1'b1;
	end

	// ====================
	// freeze flag and status

	always_ff @(posedge CLK50 or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			cfgFreeze <= 1'b0;
			cfgStatus <= '0;
		end
		else
		begin
			// set by any accepted word, cleared as the counter wraps to zero
			cfgFreeze <= (cfgFreeze | wrEn) & ~(&initCnt);
			// at least half the depth is in use
			cfgStatus.halfFull <= |wrLevel[`DR_FIFO_AW -: 2];
			cfgStatus.engine <= drStatus;
		end
	end

endmodule

`default_nettype wire

// File: hw/drWordFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dr_cfg.svh"

module drWordFifo
(
	input  wire                  CLK50,
	input  wire                  DRCLK,
	input  wire                  DRFifoReset,
	input  wire                  wrEn,
	input  wire drWordPkg::cfgWordT wrData,
	output logic                 full,
	output drWordPkg::fifoLevelT wrLevel,
	input  wire                  rdEn,
	output drWordPkg::cfgWordT   rdData,
	output drWordPkg::fifoLevelT rdLevel
);

	localparam int Depth = 1 << `DR_FIFO_AW;

	drWordPkg::cfgWordT mem [Depth];

	// pointers carry one wrap bit above the address
	logic [`DR_FIFO_AW:0] wrBin, wrBinNext, wrGray;
	logic [`DR_FIFO_AW:0] rdBin, rdBinNext, rdGray;
	logic [`DR_FIFO_AW:0] rdGraySync [`DR_SYNC_STAGES];
	logic [`DR_FIFO_AW:0] wrGraySync [`DR_SYNC_STAGES];

	function automatic logic [`DR_FIFO_AW:0] grayToBin(input logic [`DR_FIFO_AW:0] gray);
		logic [`DR_FIFO_AW:0] bin;
		bin[`DR_FIFO_AW] = gray[`DR_FIFO_AW];
		for (int i = `DR_FIFO_AW - 1; i >= 0; i--)
			bin[i] = bin[i + 1] ^ gray[i];
		return bin;
	endfunction

	// ====================
	// write side, CLK50

	assign wrBinNext = wrBin + 1'b1;

	always_ff @(posedge CLK50 or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			wrBin <= '0;
			wrGray <= '0;
		end
		else if (wrEn)
		begin
			wrBin <= wrBinNext;
			wrGray <= wrBinNext ^ (wrBinNext >> 1);
		end
	end

	always_ff @(posedge CLK50)
	begin
		if (wrEn)
			mem[wrBin[`DR_FIFO_AW-1:0]] <= wrData;
	end

	// read pointer into CLK50
	always_ff @(posedge CLK50 or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			for (int i = 0; i < `DR_SYNC_STAGES; i++)
				rdGraySync[i] <= '0;
		end
		else
		begin
			rdGraySync[0] <= rdGray;
			for (int i = 1; i < `DR_SYNC_STAGES; i++)
				rdGraySync[i] <= rdGraySync[i - 1];
		end
	end

	assign wrLevel = wrBin - grayToBin(rdGraySync[`DR_SYNC_STAGES-1]);
	assign full = wrLevel[`DR_FIFO_AW];

	// ====================
	// read side, DRCLK

	assign rdBinNext = rdBin + 1'b1;

	always_ff @(posedge DRCLK or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			rdBin <= '0;
			rdGray <= '0;
		end
		else if (rdEn)
		begin
			rdBin <= rdBinNext;
			rdGray <= rdBinNext ^ (rdBinNext >> 1);
		end
	end

	// write pointer into DRCLK
	always_ff @(posedge DRCLK or negedge DRFifoReset)
	begin
		if (~DRFifoReset)
		begin
			for (int i = 0; i < `DR_SYNC_STAGES; i++)
				wrGraySync[i] <= '0;
		end
		else
		begin
			wrGraySync[0] <= wrGray;
			for (int i = 1; i < `DR_SYNC_STAGES; i++)
				wrGraySync[i] <= wrGraySync[i - 1];
		end
	end

	assign rdLevel = grayToBin(wrGraySync[`DR_SYNC_STAGES-1]) - rdBin;

	// show-ahead, head word always on the output
	assign rdData = mem[rdBin[`DR_FIFO_AW-1:0]];

endmodule

`default_nettype wire

// File: hw/drWordPkg.sv
`default_nettype none

`include "dr_cfg.svh"

package drWordPkg;

	// one configuration word as seen by the reconfiguration engine
	typedef logic [`DR_WORD_WIDTH-1:0] cfgWordT;

	// write request from the control side, plain strobe with data
	typedef struct packed
	{
		logic    strobe;
		cfgWordT word;
	} cfgWriteT;

	// fill level, one bit wider than the pointer so 16 fits
	typedef logic [`DR_FIFO_AW:0] fifoLevelT;

endpackage

`default_nettype wire

// File: hw/dr_cfg.svh
`ifndef DR_CFG_SVH
`define DR_CFG_SVH

// configuration word width
`define DR_WORD_WIDTH 32

// log2 of reconfiguration fifo depth, 16 words
`define DR_FIFO_AW 4

// flops per clock crossing synchroniser
`define DR_SYNC_STAGES 2

// reinitialisation counter width, wraps after 1024 cycles
`define DR_INIT_BITS 10

`endif

// File: src.f
+incdir+hw
hw/drWordPkg.sv
hw/drCtrlPkg.sv
hw/drSequencer.sv
hw/drWordFifo.sv
hw/drReadPort.sv
hw/drReconfigTop.sv
test/drReconfigTop_props.sv
test/tb_drReconfigTop.sv

// File: test/drReconfigTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module drReconfigTop_props
(
	input wire                       CLK50,
	input wire                       DRCLK,
	input wire                       DRFifoReset,
	input wire drWordPkg::fifoLevelT wrLevel,
	input wire                       drValid,
	input wire                       drReady,
	input wire drWordPkg::cfgWordT   drData,
	input wire                       drFreeze,
	input wire                       cfgFreeze
);

	// failed properties so far
	int failCount = 0;

	function automatic void countFailure(input string what);
		failCount++;
		$error("%s", what);
	endfunction

	// nothing offered once the write side sees an empty fifo
	emptyNoValid: assert property (@(posedge DRCLK) disable iff (!DRFifoReset)
		wrLevel == '0 |-> !drValid)
	else countFailure("drValid high while the fifo is empty");

	// head word held during back-pressure
	stallHoldsData: assert property (@(posedge DRCLK) disable iff (!DRFifoReset)
		drValid && !drReady |=> $stable(drData))
	else countFailure("drData changed while drReady was low");

	// freeze ends only after the engine let go of drFreeze
	freezeAfterEngine: assert property (@(posedge CLK50) disable iff (!DRFifoReset)
		$fell(cfgFreeze) |-> !$past(drFreeze))
	else countFailure("cfgFreeze fell while drFreeze was high");

endmodule

bind drReconfigTop drReconfigTop_props i_drReconfigTop_props (
	.CLK50(CLK50), .DRCLK(DRCLK), .DRFifoReset(DRFifoReset), .wrLevel(wrLevel),
	.drValid(drValid), .drReady(drReady), .drData(drData), .drFreeze(drFreeze),
	.cfgFreeze(cfgFreeze)
);

`default_nettype wire

// File: test/tb_drReconfigTop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_drReconfigTop;

	typedef struct packed
	{
		drWordPkg::cfgWordT word;
		logic [3:0]         hold;
	} stimEntryT;

	// word for the engine, then DRCLK cycles of drReady low before it is taken
	// engine status for each write is the low three bits of its word
	localparam stimEntryT stimTable [20] = '{
		'{32'hA5A5_0001, 4'd0}, '{32'h5A5A_0102, 4'd3}, '{32'h1DEA_BEE3, 4'd1}, '{32'h0F0F_F0F4, 4'd0},
		'{32'h1234_5675, 4'd2}, '{32'h6A1E_0006, 4'd5}, '{32'h8000_0007, 4'd0}, '{32'h7FFF_FFF8, 4'd1},
		'{32'h0BAD_F009, 4'd4}, '{32'hFFFF_FFFA, 4'd0}, '{32'h0000_000B, 4'd2}, '{32'h3C3C_3C3C, 4'd1},
		'{32'hC3C3_C3CD, 4'd0}, '{32'h2468_ACEE, 4'd3}, '{32'h1357_9BDF, 4'd0}, '{32'h0101_0100, 4'd6},
		'{32'hFEDC_BA91, 4'd1}, '{32'h89AB_CDE2, 4'd0}, '{32'h4444_4443, 4'd2}, '{32'h2E2F_0004, 4'd7}
	};

	logic CLK50 = 1'b0;
	logic DRCLK = 1'b0;
	logic DRFifoReset, cfgRequest, drFreeze, drReady;
	drWordPkg::cfgWriteT cfgWrite;
	drCtrlPkg::engineStatusT drStatus;
	wire drValid, drStart, cfgFreeze;
	wire drWordPkg::cfgWordT drData;
	wire drCtrlPkg::drStatusT cfgStatus;
	int valueErrors = 0;
	int timeouts = 0;

	always #5 CLK50 = ~CLK50;
	always #7 DRCLK = ~DRCLK;

	drReconfigTop i_drReconfigTop (
		.CLK50(CLK50), .DRCLK(DRCLK), .DRFifoReset(DRFifoReset), .cfgWrite(cfgWrite),
		.cfgRequest(cfgRequest), .drFreeze(drFreeze), .drStatus(drStatus), .drReady(drReady),
		.drValid(drValid), .drData(drData), .drStart(drStart), .cfgFreeze(cfgFreeze),
		.cfgStatus(cfgStatus)
	);

	task automatic checkValue(input string what, input logic [31:0] got, exp);
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	// writes count table words with drReady low, then reads back what the fifo kept
	task automatic runBatch(input int first, input int count, input bit stall);
		int waitCnt;
		for (int i = first; i < first + count; i++)
		begin
			@(negedge CLK50);
			cfgWrite.strobe = 1'b1;
			cfgWrite.word = stimTable[i].word;
			drStatus = stimTable[i].word[2:0];
			@(negedge CLK50);
			cfgWrite.strobe = 1'b0;
			checkValue("cfgStatus.engine", 32'(cfgStatus.engine), 32'(stimTable[i].word[2:0]));
			checkValue("cfgFreeze", 32'(cfgFreeze), 1);
		end
		for (waitCnt = 0; waitCnt < 8 && !cfgStatus.halfFull; waitCnt++)
			@(negedge CLK50);
		if (!cfgStatus.halfFull)
			reportTimeout("cfgStatus.halfFull");
		// a full fifo keeps only 16 words
		for (int i = first; i < first + ((count > 16) ? 16 : count); i++)
		begin
			repeat (stall ? stimTable[i].hold + int'($urandom % 4) : 0) @(negedge DRCLK);
			@(negedge DRCLK);
			for (waitCnt = 0; waitCnt < 20 && !drValid; waitCnt++)
				@(negedge DRCLK);
			if (!drValid)
				reportTimeout("drValid");
			checkValue("drData", drData, stimTable[i].word);
			drReady = 1'b1;
			@(negedge DRCLK);
			drReady = 1'b0;
		end
		// read pointer settles on the write side too
		repeat (4) @(negedge CLK50);
		checkValue("drValid after draining", 32'(drValid), 0);
	endtask

	initial
	begin
		int freezeCycles;
		int waitCnt;
		void'($urandom(68276));
		DRFifoReset = 1'b0;
		cfgWrite = '0;
		cfgRequest = 1'b0;
		drFreeze = 1'b0;
		drStatus = '0;
		drReady = 1'b0;
		repeat (16) @(posedge CLK50);
		@(negedge CLK50);
		DRFifoReset = 1'b1;
		@(negedge CLK50);
		checkValue("reset state", 32'({drValid, drStart, cfgFreeze, cfgStatus.halfFull}), 0);

		// ====================
		// word transport
		runBatch(0, 9, 1'b1);
		runBatch(9, 11, 1'b1);
		// overflow, the last four strobes are lost
		runBatch(0, 20, 1'b0);

		// ====================
		// end of freeze
		@(negedge CLK50);
		drFreeze = 1'b1;
		repeat (8) @(negedge CLK50);
		drFreeze = 1'b0;
		for (freezeCycles = 0; freezeCycles < 1100 && cfgFreeze; freezeCycles++)
			@(negedge CLK50);
		if (cfgFreeze)
			reportTimeout("cfgFreeze to fall");
		else
			checkValue("cfgFreeze held 1000 cycles", 32'(freezeCycles >= 1000), 1);

		// ====================
		// start request
		repeat (4)
		begin
			@(negedge CLK50);
			cfgRequest = ~cfgRequest;
			for (waitCnt = 0; waitCnt < 10 && drStart !== cfgRequest; waitCnt++)
				@(negedge DRCLK);
			if (drStart !== cfgRequest)
				reportTimeout("drStart to follow cfgRequest");
		end

		$display("value errors %0d, timeouts %0d, property failures %0d",
			valueErrors, timeouts, i_drReconfigTop.i_drReconfigTop_props.failCount);
		if (valueErrors + timeouts + i_drReconfigTop.i_drReconfigTop_props.failCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
